// ==== project.f ====
source/net_pkg.sv
source/forward_table.sv
source/net_controller.sv
source/port_connector.sv
source/switch_fabric.sv
source/silicon_net.sv
sim/silicon_net_sva.sv
sim/tb_silicon_net.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_silicon_net -f project.f -o tb_silicon_net

out=$(./obj_dir/tb_silicon_net 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "TEST PASSED"; then
    exit 0
fi
exit 1

// ==== sim/tb_silicon_net.sv ====
// Testbench for the message network: random tables and traffic, checked against a routing model
`timescale 1ns/1ps

module tb_silicon_net;
    import net_pkg::*;

    localparam int MSGS_PER_PORT   = 40;
    localparam int MAX_LEN         = 6;
    localparam int MARGIN          = 10;
    localparam int SETUP_CYCLES    = 2000;
    localparam int WATCHDOG_CYCLES = NUM_PORTS * MSGS_PER_PORT * MAX_LEN * MARGIN + SETUP_CYCLES;

    typedef struct packed {
        logic              drop;
        logic              first;
        logic              last;
        logic [DATA_W-1:0] data;
    } beat_t;

    logic               clk          = 1'b0;
    logic               rst_n_i      = 1'b0;
    logic [DATA_W-1:0]  sa_data_i    [NUM_PORTS] = '{default: '0};
    logic               sa_valid_i   [NUM_PORTS] = '{default: 1'b0};
    logic               sa_first_i   [NUM_PORTS] = '{default: 1'b0};
    logic               sa_last_i    [NUM_PORTS] = '{default: 1'b0};
    logic               sa_ready_i   [NUM_PORTS] = '{default: 1'b0};
    logic               ctl_read_i   = 1'b0;
    logic               ctl_write_i  = 1'b0;
    logic [ADDR_W-1:0]  ctl_addr_i   = '0;
    logic [DATA_W-1:0]  ctl_wrdata_i = '0;
    logic [DATA_W-1:0]  sa_data_o    [NUM_PORTS];
    logic               sa_valid_o   [NUM_PORTS];
    logic               sa_first_o   [NUM_PORTS];
    logic               sa_last_o    [NUM_PORTS];
    logic               sa_ready_o   [NUM_PORTS];
    logic [DATA_W-1:0]  ctl_rddata_o;
    logic               ctl_rdvalid_o;

    // Model of every forwarding table
    logic [KEY_W-1:0]   m_key   [NUM_PORTS][NUM_ENTRIES];
    logic [KEY_W-1:0]   m_mask  [NUM_PORTS][NUM_ENTRIES];
    logic [PORT_W-1:0]  m_ep    [NUM_PORTS][NUM_ENTRIES];
    logic               m_valid [NUM_PORTS][NUM_ENTRIES];
    int                 fwd_cnt  [NUM_PORTS] = '{default: 0};
    int                 drop_cnt [NUM_PORTS] = '{default: 0};

    // Beats still to send per source, expected beats per source/destination pair
    beat_t              tx_q  [NUM_PORTS][$];
    beat_t              exp_q [NUM_PORTS*NUM_PORTS][$];
    logic [PORT_W-1:0]  rx_src [NUM_PORTS];

    silicon_net u_dut (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .sa_data_o     (sa_data_o),
        .sa_valid_o    (sa_valid_o),
        .sa_first_o    (sa_first_o),
        .sa_last_o     (sa_last_o),
        .sa_ready_i    (sa_ready_i),
        .sa_data_i     (sa_data_i),
        .sa_valid_i    (sa_valid_i),
        .sa_first_i    (sa_first_i),
        .sa_last_i     (sa_last_i),
        .sa_ready_o    (sa_ready_o),
        .ctl_read_i    (ctl_read_i),
        .ctl_write_i   (ctl_write_i),
        .ctl_addr_i    (ctl_addr_i),
        .ctl_wrdata_i  (ctl_wrdata_i),
        .ctl_rddata_o  (ctl_rddata_o),
        .ctl_rdvalid_o (ctl_rdvalid_o)
    );

    always #5 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic compare_value(input string name, input logic [DATA_W-1:0] got,
                                 input logic [DATA_W-1:0] want);
        if (got !== want) begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, want);
            abort_run();
        end
    endtask

    function automatic logic [ADDR_W-1:0] make_addr(input ctl_op_e op, input int port,
                                                    input int idx);
        logic [ADDR_W-1:0] a;
        a                = '0;
        a[OP_LSB +: 4]   = op;
        a[PORT_LSB +: 4] = port[3:0];
        a[IDX_LSB +: 4]  = idx[3:0];
        return a;
    endfunction

    function automatic logic [DATA_W-1:0] entry_word(input int p, input int e);
        logic [DATA_W-1:0] w;
        w                     = '0;
        w[KEY_LSB +: KEY_W]   = m_key[p][e];
        w[MASK_LSB +: KEY_W]  = m_mask[p][e];
        w[EP_LSB +: PORT_W]   = m_ep[p][e];
        w[VALID_BIT]          = m_valid[p][e];
        return w;
    endfunction

    // First valid entry whose masked bits agree with the key decides the route
    function automatic logic route_key(input int p, input logic [KEY_W-1:0] key,
                                       output logic [PORT_W-1:0] ep);
        ep = '0;
        for (int e = 0; e < NUM_ENTRIES; e++) begin
            if (m_valid[p][e] && ((key & m_mask[p][e]) == (m_key[p][e] & m_mask[p][e]))) begin
                ep = m_ep[p][e];
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic write_reg(input ctl_op_e op, input int port, input int idx,
                             input logic [DATA_W-1:0] data);
        @(posedge clk);
        ctl_write_i  <= 1'b1;
        ctl_addr_i   <= make_addr(op, port, idx);
        ctl_wrdata_i <= data;
        @(posedge clk);
        ctl_write_i  <= 1'b0;
    endtask

    // Reply must show up in the second cycle after the request cycle, not earlier
    task automatic read_reg(input ctl_op_e op, input int port, input int idx,
                            output logic [DATA_W-1:0] data);
        @(posedge clk);
        ctl_read_i <= 1'b1;
        ctl_addr_i <= make_addr(op, port, idx);
        for (int c = 0; c < 2; c++) begin
            @(posedge clk);
            ctl_read_i <= 1'b0;
            compare_value("ctl_rdvalid_o", 32'(ctl_rdvalid_o), '0);
        end
        @(posedge clk);
        compare_value("ctl_rdvalid_o", 32'(ctl_rdvalid_o), 32'd1);
        data = ctl_rddata_o;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus and scoreboard
    ////////////////////////////////////////////////////////////////////////////

    task automatic configure_tables();
        logic [DATA_W-1:0] r;
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int e = 0; e < NUM_ENTRIES; e++) begin
                r = $urandom;
                if (e == 1) begin
                    // Same match as entry 0 but another endpoint
                    m_key[p][1]   = m_key[p][0];
                    m_mask[p][1]  = m_mask[p][0];
                    m_ep[p][1]    = m_ep[p][0] + PORT_W'(1);
                    m_valid[p][1] = 1'b1;
                end else begin
                    m_key[p][e]   = r[7:0];
                    m_mask[p][e]  = r[15:8];
                    m_ep[p][e]    = r[17:16];
                    m_valid[p][e] = (e == 0) || (r[20:19] != 2'b00);
                end
                write_reg(OP_WRITE_ENTRY, p, e, entry_word(p, e));
            end
        end
    endtask

    task automatic build_messages();
        logic [DATA_W-1:0] r;
        logic [KEY_W-1:0]  key;
        logic [PORT_W-1:0] ep;
        logic              hit;
        int                len;
        int                e;
        beat_t             b;
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int m = 0; m < MSGS_PER_PORT; m++) begin
                len = $urandom_range(MAX_LEN, 1);
                e   = $urandom_range(NUM_ENTRIES - 1);
                r   = $urandom;
                // Mostly keys aimed at some entry, the rest free
                if ($urandom_range(3) != 0) begin
                    key = (m_key[p][e] & m_mask[p][e]) | (r[7:0] & ~m_mask[p][e]);
                end else begin
                    key = r[7:0];
                end
                hit = route_key(p, key, ep);
                if (hit) begin
                    fwd_cnt[p]++;
                end else begin
                    drop_cnt[p]++;
                end
                for (int i = 0; i < len; i++) begin
                    b.drop                   = !hit;
                    b.first                  = (i == 0);
                    b.last                   = (i == len - 1);
                    b.data                   = $urandom;
                    b.data[KEY_W +: PORT_W]  = PORT_W'(p);
                    if (i == 0) begin
                        b.data[KEY_W-1:0] = key;
                    end
                    tx_q[p].push_back(b);
                    if (hit) begin
                        exp_q[p * NUM_PORTS + int'(ep)].push_back(b);
                    end
                end
            end
        end
    endtask

    function automatic logic traffic_left();
        for (int i = 0; i < NUM_PORTS * NUM_PORTS; i++) begin
            if (exp_q[i].size() > 0 || (i < NUM_PORTS && tx_q[i].size() > 0)) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // One clock of traffic on values sampled before the edge
    task automatic step_traffic();
        int q;
        for (int p = 0; p < NUM_PORTS; p++) begin
            // Discarded messages are never back-pressured
            if (sa_valid_i[p] && tx_q[p][0].drop) begin
                compare_value("sa_ready_o", 32'(sa_ready_o[p]), 32'd1);
            end
            if (sa_valid_i[p] && sa_ready_o[p]) begin
                void'(tx_q[p].pop_front());
            end
            if (!(sa_valid_i[p] && !sa_ready_o[p])) begin
                if (tx_q[p].size() > 0 && $urandom_range(3) != 0) begin
                    sa_valid_i[p] <= 1'b1;
                    sa_first_i[p] <= tx_q[p][0].first;
                    sa_last_i[p]  <= tx_q[p][0].last;
                    sa_data_i[p]  <= tx_q[p][0].data;
                end else begin
                    sa_valid_i[p] <= 1'b0;
                end
            end
        end
        for (int d = 0; d < NUM_PORTS; d++) begin
            if (sa_valid_o[d] && sa_ready_i[d]) begin
                // Source id rides in every beat
                if (sa_first_o[d]) begin
                    rx_src[d] = sa_data_o[d][KEY_W +: PORT_W];
                end
                q = int'(rx_src[d]) * NUM_PORTS + d;
                if (exp_q[q].size() == 0) begin
                    $display("RX port %0d delivered a beat that no routed message accounts for", d);
                    abort_run();
                end else begin
                    compare_value("sa_first_o", 32'(sa_first_o[d]), 32'(exp_q[q][0].first));
                    compare_value("sa_last_o", 32'(sa_last_o[d]), 32'(exp_q[q][0].last));
                    compare_value("sa_data_o", sa_data_o[d], exp_q[q][0].data);
                    void'(exp_q[q].pop_front());
                end
            end
            sa_ready_i[d] <= ($urandom_range(3) != 0);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [DATA_W-1:0] rdata;
        int                idle;
        void'($urandom(32'h6cad));
        repeat (5) @(posedge clk);
        rst_n_i <= 1'b1;

        configure_tables();
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int e = 0; e < NUM_ENTRIES; e++) begin
                read_reg(OP_READ_ENTRY, p, e, rdata);
                compare_value("ctl_rddata_o", rdata, entry_word(p, e));
            end
        end

        // Run until everything drains, then watch a while for stray beats
        build_messages();
        idle = 0;
        while (idle < 50) begin
            @(posedge clk);
            step_traffic();
            if (traffic_left()) begin
                idle = 0;
            end else begin
                idle++;
            end
        end

        for (int p = 0; p < NUM_PORTS; p++) begin
            read_reg(OP_READ_COUNTER, p, int'(CNT_FORWARDED), rdata);
            compare_value("ctl_rddata_o", rdata, DATA_W'(fwd_cnt[p]));
            read_reg(OP_READ_COUNTER, p, int'(CNT_DROPPED), rdata);
            compare_value("ctl_rddata_o", rdata, DATA_W'(drop_cnt[p]));
        end

        $display("TEST PASSED");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles with traffic still pending", WATCHDOG_CYCLES);
        abort_run();
    end

endmodule

// ==== sim/silicon_net_sva.sv ====
// Lock and hold assertions for the crossbar, bound into switch_fabric by the bind at the bottom
`timescale 1ns/1ps

module silicon_net_sva (
    input logic                       clk,
    input logic                       rst_n_i,
    input logic                       busy_q      [net_pkg::NUM_PORTS],
    input logic [net_pkg::PORT_W-1:0] owner_q     [net_pkg::NUM_PORTS],
    input logic                       out_valid_o [net_pkg::NUM_PORTS],
    input logic                       out_first_o [net_pkg::NUM_PORTS],
    input logic                       out_last_o  [net_pkg::NUM_PORTS],
    input logic [net_pkg::DATA_W-1:0] out_data_o  [net_pkg::NUM_PORTS],
    input logic                       out_ready_i [net_pkg::NUM_PORTS]
);
    import net_pkg::*;

    for (genvar o = 0; o < NUM_PORTS; o++) begin : gen_out
        // An output leaving idle opens with a first beat
        a_lock_opens: assert property (@(posedge clk) disable iff (!rst_n_i)
            (out_valid_o[o] && !$past(busy_q[o])) |-> out_first_o[o])
            else $error("output %0d left idle on a beat that does not open a message", o);

        // Back-pressured beat is held unchanged
        a_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
            (out_valid_o[o] && !out_ready_i[o]) |=>
                (out_valid_o[o] && $stable(out_data_o[o]) &&
                 $stable(out_first_o[o]) && $stable(out_last_o[o])))
            else $error("output %0d changed a beat that was not taken", o);

        for (genvar j = o + 1; j < NUM_PORTS; j++) begin : gen_pair
            a_one_owner: assert property (@(posedge clk) disable iff (!rst_n_i)
                !(busy_q[o] && busy_q[j] && (owner_q[o] == owner_q[j])))
                else $error("outputs %0d and %0d are locked to one input", o, j);
        end
    end

endmodule

bind switch_fabric silicon_net_sva u_sva (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .busy_q      (busy_q),
    .owner_q     (owner_q),
    .out_valid_o (out_valid_o),
    .out_first_o (out_first_o),
    .out_last_o  (out_last_o),
    .out_data_o  (out_data_o),
    .out_ready_i (out_ready_i)
);

// ==== source/silicon_net.sv ====
// Top level of the four-port message network: register controller, port connectors and crossbar
`timescale 1ns/1ps

module silicon_net (
    input  logic                        clk,
    input  logic                        rst_n_i,

    // RX side
    output logic [net_pkg::DATA_W-1:0]  sa_data_o   [net_pkg::NUM_PORTS],
    output logic                        sa_valid_o  [net_pkg::NUM_PORTS],
    output logic                        sa_first_o  [net_pkg::NUM_PORTS],
    output logic                        sa_last_o   [net_pkg::NUM_PORTS],
    input  logic                        sa_ready_i  [net_pkg::NUM_PORTS],

    // TX side
    input  logic [net_pkg::DATA_W-1:0]  sa_data_i   [net_pkg::NUM_PORTS],
    input  logic                        sa_valid_i  [net_pkg::NUM_PORTS],
    input  logic                        sa_first_i  [net_pkg::NUM_PORTS],
    input  logic                        sa_last_i   [net_pkg::NUM_PORTS],
    output logic                        sa_ready_o  [net_pkg::NUM_PORTS],

    // Register bus
    input  logic                        ctl_read_i,
    input  logic                        ctl_write_i,
    input  logic [net_pkg::ADDR_W-1:0]  ctl_addr_i,
    input  logic [net_pkg::DATA_W-1:0]  ctl_wrdata_i,
    output logic [net_pkg::DATA_W-1:0]  ctl_rddata_o,
    output logic                        ctl_rdvalid_o
);
    import net_pkg::*;

    // Controller to connectors
    logic               cfg_wr       [NUM_PORTS];
    logic               cfg_rd_entry [NUM_PORTS];
    logic               cnt_rd       [NUM_PORTS];
    logic [ENTRY_W-1:0] cfg_idx;
    logic [DATA_W-1:0]  cfg_entry;
    cnt_sel_e           cnt_sel;
    logic               rd_valid     [NUM_PORTS];
    logic [DATA_W-1:0]  rd_data      [NUM_PORTS];

    // Connectors to switch
    logic               req_valid    [NUM_PORTS];
    logic               req_first    [NUM_PORTS];
    logic               req_last     [NUM_PORTS];
    logic [DATA_W-1:0]  req_data     [NUM_PORTS];
    logic [PORT_W-1:0]  req_dest     [NUM_PORTS];
    logic               req_ready    [NUM_PORTS];

    net_controller u_ctrl (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .ctl_read_i     (ctl_read_i),
        .ctl_write_i    (ctl_write_i),
        .ctl_addr_i     (ctl_addr_i),
        .ctl_wrdata_i   (ctl_wrdata_i),
        .ctl_rddata_o   (ctl_rddata_o),
        .ctl_rdvalid_o  (ctl_rdvalid_o),
        .rd_valid_i     (rd_valid),
        .rd_data_i      (rd_data),
        .cfg_wr_o       (cfg_wr),
        .cfg_rd_entry_o (cfg_rd_entry),
        .cnt_rd_o       (cnt_rd),
        .cfg_idx_o      (cfg_idx),
        .cfg_entry_o    (cfg_entry),
        .cnt_sel_o      (cnt_sel)
    );

    for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_port
        port_connector u_conn (
            .clk            (clk),
            .rst_n_i        (rst_n_i),
            .sa_data_i      (sa_data_i[p]),
            .sa_valid_i     (sa_valid_i[p]),
            .sa_first_i     (sa_first_i[p]),
            .sa_last_i      (sa_last_i[p]),
            .sa_ready_o     (sa_ready_o[p]),
            .cfg_wr_i       (cfg_wr[p]),
            .cfg_rd_entry_i (cfg_rd_entry[p]),
            .cnt_rd_i       (cnt_rd[p]),
            .cfg_idx_i      (cfg_idx),
            .cfg_entry_i    (cfg_entry),
            .cnt_sel_i      (cnt_sel),
            .rd_valid_o     (rd_valid[p]),
            .rd_data_o      (rd_data[p]),
            .req_valid_o    (req_valid[p]),
            .req_first_o    (req_first[p]),
            .req_last_o     (req_last[p]),
            .req_data_o     (req_data[p]),
            .req_dest_o     (req_dest[p]),
            .req_ready_i    (req_ready[p])
        );
    end

    // Switch outputs drive the RX side directly
    switch_fabric u_switch (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .req_valid_i (req_valid),
        .req_first_i (req_first),
        .req_last_i  (req_last),
        .req_data_i  (req_data),
        .req_dest_i  (req_dest),
        .req_ready_o (req_ready),
        .out_valid_o (sa_valid_o),
        .out_first_o (sa_first_o),
        .out_last_o  (sa_last_o),
        .out_data_o  (sa_data_o),
        .out_ready_i (sa_ready_i)
    );

endmodule

// ==== source/switch_fabric.sv ====
// Crossbar that locks each output to one input for a whole message, round-robin among requesters
`timescale 1ns/1ps

module switch_fabric (
    input  logic                       clk,
    input  logic                       rst_n_i,

    // Per input
    input  logic                       req_valid_i [net_pkg::NUM_PORTS],
    input  logic                       req_first_i [net_pkg::NUM_PORTS],
    input  logic                       req_last_i  [net_pkg::NUM_PORTS],
    input  logic [net_pkg::DATA_W-1:0] req_data_i  [net_pkg::NUM_PORTS],
    input  logic [net_pkg::PORT_W-1:0] req_dest_i  [net_pkg::NUM_PORTS],
    output logic                       req_ready_o [net_pkg::NUM_PORTS],

    // Per output
    output logic                       out_valid_o [net_pkg::NUM_PORTS],
    output logic                       out_first_o [net_pkg::NUM_PORTS],
    output logic                       out_last_o  [net_pkg::NUM_PORTS],
    output logic [net_pkg::DATA_W-1:0] out_data_o  [net_pkg::NUM_PORTS],
    input  logic                       out_ready_i [net_pkg::NUM_PORTS]
);
    import net_pkg::*;

    // Lock state per output
    logic              busy_q    [NUM_PORTS];
    logic [PORT_W-1:0] owner_q   [NUM_PORTS];
    logic [PORT_W-1:0] last_q    [NUM_PORTS];

    logic              grant_v   [NUM_PORTS];
    logic [PORT_W-1:0] grant_idx [NUM_PORTS];

    ////////////////////////////////////////////////////////////////////////////
    // Arbitration
    ////////////////////////////////////////////////////////////////////////////

    // Candidates scanned from farthest to nearest after the last winner,
    // so the nearest requester is the one kept
    always_comb begin
        logic [PORT_W-1:0] cand;
        for (int o = 0; o < NUM_PORTS; o++) begin
            grant_v[o]   = 1'b0;
            grant_idx[o] = last_q[o];
            for (int k = NUM_PORTS; k >= 1; k--) begin
                cand = last_q[o] + PORT_W'(k);
                if (req_valid_i[cand] && req_first_i[cand] && (req_dest_i[cand] == PORT_W'(o))) begin
                    grant_v[o]   = 1'b1;
                    grant_idx[o] = cand;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int o = 0; o < NUM_PORTS; o++) begin
                busy_q[o]  <= 1'b0;
                owner_q[o] <= '0;
                last_q[o]  <= PORT_W'(NUM_PORTS - 1);
            end
        end else begin
            for (int o = 0; o < NUM_PORTS; o++) begin
                if (!busy_q[o] && grant_v[o]) begin
                    busy_q[o]  <= 1'b1;
                    owner_q[o] <= grant_idx[o];
                    last_q[o]  <= grant_idx[o];
                end else if (out_valid_o[o] && out_ready_i[o] && out_last_o[o]) begin
                    busy_q[o] <= 1'b0;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int o = 0; o < NUM_PORTS; o++) begin
            out_valid_o[o] = busy_q[o] && req_valid_i[owner_q[o]];
            out_first_o[o] = req_first_i[owner_q[o]];
            out_last_o[o]  = req_last_i[owner_q[o]];
            out_data_o[o]  = req_data_i[owner_q[o]];
        end
    end

    // Ready goes back to the owner only
    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            req_ready_o[i] = 1'b0;
        end
        for (int o = 0; o < NUM_PORTS; o++) begin
            if (busy_q[o]) begin
                req_ready_o[owner_q[o]] = out_ready_i[o];
            end
        end
    end

endmodule

// ==== source/port_connector.sv ====
// Per-port TX framing, route lookup, discard of unroutable messages, counters and read replies
`timescale 1ns/1ps

module port_connector (
    input  logic                        clk,
    input  logic                        rst_n_i,

    // TX beats from the stack/app side
    input  logic [net_pkg::DATA_W-1:0]  sa_data_i,
    input  logic                        sa_valid_i,
    input  logic                        sa_first_i,
    input  logic                        sa_last_i,
    output logic                        sa_ready_o,

    // Configuration from the controller
    input  logic                        cfg_wr_i,
    input  logic                        cfg_rd_entry_i,
    input  logic                        cnt_rd_i,
    input  logic [net_pkg::ENTRY_W-1:0] cfg_idx_i,
    input  logic [net_pkg::DATA_W-1:0]  cfg_entry_i,
    input  net_pkg::cnt_sel_e           cnt_sel_i,
    output logic                        rd_valid_o,
    output logic [net_pkg::DATA_W-1:0]  rd_data_o,

    // Toward the switch
    output logic                        req_valid_o,
    output logic                        req_first_o,
    output logic                        req_last_o,
    output logic [net_pkg::DATA_W-1:0]  req_data_o,
    output logic [net_pkg::PORT_W-1:0]  req_dest_o,
    input  logic                        req_ready_i
);
    import net_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FWD,
        ST_DROP
    } state_e;

    state_e            state_q;
    logic [PORT_W-1:0] dest_q;
    logic              hit;
    logic [PORT_W-1:0] hit_ep;
    logic [DATA_W-1:0] tbl_entry;
    logic              fwd_now;
    logic              drop_now;
    logic              beat;
    logic [CNT_W-1:0]  fwd_cnt_q;
    logic [CNT_W-1:0]  drop_cnt_q;

    forward_table u_table (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .wr_i         (cfg_wr_i),
        .wr_idx_i     (cfg_idx_i),
        .wr_entry_i   (cfg_entry_i),
        .lookup_key_i (sa_data_i[KEY_W-1:0]),
        .hit_o        (hit),
        .hit_ep_o     (hit_ep),
        .rd_idx_i     (cfg_idx_i),
        .rd_entry_o   (tbl_entry)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Framing
    ////////////////////////////////////////////////////////////////////////////

    // A beat seen in idle opens a message and is routed on its key
    always_comb begin
        fwd_now    = 1'b0;
        drop_now   = 1'b0;
        req_dest_o = dest_q;
        case (state_q)
            ST_IDLE: begin
                fwd_now    = hit;
                drop_now   = !hit;
                req_dest_o = hit_ep;
            end
            ST_FWD:  fwd_now  = 1'b1;
            default: drop_now = 1'b1;
        endcase
    end

    assign req_valid_o = sa_valid_i && fwd_now;
    assign req_first_o = sa_first_i;
    assign req_last_o  = sa_last_i;
    assign req_data_o  = sa_data_i;
    assign sa_ready_o  = drop_now || (fwd_now && req_ready_i);
    assign beat        = sa_valid_i && sa_ready_o;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= ST_IDLE;
            fwd_cnt_q  <= '0;
            drop_cnt_q <= '0;
        end else if (beat) begin
            if (sa_last_i) begin
                state_q <= ST_IDLE;
            end else if (state_q == ST_IDLE) begin
                state_q <= hit ? ST_FWD : ST_DROP;
            end
            // Messages are counted on their last beat
            if (sa_last_i && fwd_now) begin
                fwd_cnt_q <= fwd_cnt_q + 1'b1;
            end
            if (sa_last_i && drop_now) begin
                drop_cnt_q <= drop_cnt_q + 1'b1;
            end
        end
    end

    // Endpoint held for the rest of the message
    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE) begin
            dest_q <= hit_ep;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read replies
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= cfg_rd_entry_i || cnt_rd_i;
        end
    end

    always_ff @(posedge clk) begin
        if (cfg_rd_entry_i) begin
            rd_data_o <= tbl_entry;
        end else begin
            case (cnt_sel_i)
                CNT_FORWARDED: rd_data_o <= DATA_W'(fwd_cnt_q);
                default:       rd_data_o <= DATA_W'(drop_cnt_q);
            endcase
        end
    end

endmodule

// ==== source/net_controller.sv ====
// Register-bus front end that turns accesses into per-port table strobes and returns read replies
`timescale 1ns/1ps

module net_controller (
    input  logic                        clk,
    input  logic                        rst_n_i,

    input  logic                        ctl_read_i,
    input  logic                        ctl_write_i,
    input  logic [net_pkg::ADDR_W-1:0]  ctl_addr_i,
    input  logic [net_pkg::DATA_W-1:0]  ctl_wrdata_i,
    output logic [net_pkg::DATA_W-1:0]  ctl_rddata_o,
    output logic                        ctl_rdvalid_o,

    input  logic                        rd_valid_i     [net_pkg::NUM_PORTS],
    input  logic [net_pkg::DATA_W-1:0]  rd_data_i      [net_pkg::NUM_PORTS],
    output logic                        cfg_wr_o       [net_pkg::NUM_PORTS],
    output logic                        cfg_rd_entry_o [net_pkg::NUM_PORTS],
    output logic                        cnt_rd_o       [net_pkg::NUM_PORTS],
    output logic [net_pkg::ENTRY_W-1:0] cfg_idx_o,
    output logic [net_pkg::DATA_W-1:0]  cfg_entry_o,
    output net_pkg::cnt_sel_e           cnt_sel_o
);
    import net_pkg::*;

    ctl_op_e           op;
    logic [PORT_W-1:0] port;
    logic              rd_pend_q;
    logic [PORT_W-1:0] rd_port_q;

    // Address split
    assign op          = ctl_op_e'(ctl_addr_i[OP_LSB +: $bits(ctl_op_e)]);
    assign port        = ctl_addr_i[PORT_LSB +: PORT_W];
    assign cfg_idx_o   = ctl_addr_i[IDX_LSB +: ENTRY_W];
    assign cfg_entry_o = ctl_wrdata_i;
    assign cnt_sel_o   = cnt_sel_e'(ctl_addr_i[IDX_LSB]);

    // One strobe toward the addressed port in the cycle of the access
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            cfg_wr_o[p]       = ctl_write_i && (op == OP_WRITE_ENTRY) && (port == PORT_W'(p));
            cfg_rd_entry_o[p] = ctl_read_i && (op == OP_READ_ENTRY) && (port == PORT_W'(p));
            cnt_rd_o[p]       = ctl_read_i && (op == OP_READ_COUNTER) && (port == PORT_W'(p));
        end
    end

    // Read pipeline of two cycles
    // Port replies in the first cycle and the bus sees it in the second
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_pend_q     <= 1'b0;
            ctl_rdvalid_o <= 1'b0;
        end else begin
            rd_pend_q     <= ctl_read_i;
            ctl_rdvalid_o <= rd_pend_q;
        end
    end

    // Unknown opcodes get no port reply and answer with zero
    always_ff @(posedge clk) begin
        rd_port_q    <= port;
        ctl_rddata_o <= rd_valid_i[rd_port_q] ? rd_data_i[rd_port_q] : '0;
    end

endmodule

// ==== source/forward_table.sv ====
// Per-port forwarding table with masked key match, lowest entry first, and register readback
`timescale 1ns/1ps

module forward_table (
    input  logic                        clk,
    input  logic                        rst_n_i,

    input  logic                        wr_i,
    input  logic [net_pkg::ENTRY_W-1:0] wr_idx_i,
    input  logic [net_pkg::DATA_W-1:0]  wr_entry_i,

    input  logic [net_pkg::KEY_W-1:0]   lookup_key_i,
    output logic                        hit_o,
    output logic [net_pkg::PORT_W-1:0]  hit_ep_o,

    input  logic [net_pkg::ENTRY_W-1:0] rd_idx_i,
    output logic [net_pkg::DATA_W-1:0]  rd_entry_o
);
    import net_pkg::*;

    logic [NUM_ENTRIES-1:0] valid_q;
    logic [KEY_W-1:0]       key_q  [NUM_ENTRIES];
    logic [KEY_W-1:0]       mask_q [NUM_ENTRIES];
    logic [PORT_W-1:0]      ep_q   [NUM_ENTRIES];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (wr_i) begin
            valid_q[wr_idx_i] <= wr_entry_i[VALID_BIT];
        end
    end

    // Entry contents
    always_ff @(posedge clk) begin
        if (wr_i) begin
            key_q[wr_idx_i]  <= wr_entry_i[KEY_LSB +: KEY_W];
            mask_q[wr_idx_i] <= wr_entry_i[MASK_LSB +: KEY_W];
            ep_q[wr_idx_i]   <= wr_entry_i[EP_LSB +: PORT_W];
        end
    end

    // Walk from the top so the lowest matching index is left standing
    always_comb begin
        hit_o    = 1'b0;
        hit_ep_o = '0;
        for (int e = NUM_ENTRIES - 1; e >= 0; e--) begin
            if (valid_q[e] && (((lookup_key_i ^ key_q[e]) & mask_q[e]) == '0)) begin
                hit_o    = 1'b1;
                hit_ep_o = ep_q[e];
            end
        end
    end

    // Readback in write-data layout
    always_comb begin
        rd_entry_o                        = '0;
        rd_entry_o[KEY_LSB +: KEY_W]      = key_q[rd_idx_i];
        rd_entry_o[MASK_LSB +: KEY_W]     = mask_q[rd_idx_i];
        rd_entry_o[EP_LSB +: PORT_W]      = ep_q[rd_idx_i];
        rd_entry_o[VALID_BIT]             = valid_q[rd_idx_i];
    end

endmodule

// ==== source/net_pkg.sv ====
// Shared widths, field positions and register-bus codes, imported by every RTL block of the network
package net_pkg;

    // Port and data sizes
    localparam int NUM_PORTS   = 4;
    localparam int PORT_W      = 2;
    localparam int DATA_W      = 32;
    localparam int KEY_W       = 8;

    // Forwarding table and counters
    localparam int NUM_ENTRIES = 8;
    localparam int ENTRY_W     = 3;
    localparam int CNT_W       = 16;

    // Register bus address width
    localparam int ADDR_W      = 16;

    // Entry layout in the write data, also used for readback
    localparam int KEY_LSB     = 0;
    localparam int MASK_LSB    = 8;
    localparam int EP_LSB      = 16;
    localparam int VALID_BIT   = 18;

    // Address fields
    localparam int IDX_LSB     = 0;
    localparam int PORT_LSB    = 4;
    localparam int OP_LSB      = 8;

    // Register-bus operations, other codes are ignored
    typedef enum logic [3:0] {
        OP_WRITE_ENTRY  = 4'd1,
        OP_READ_ENTRY   = 4'd2,
        OP_READ_COUNTER = 4'd3
    } ctl_op_e;

    // Counter select, taken from the index field
    typedef enum logic {
        CNT_FORWARDED = 1'b0,
        CNT_DROPPED   = 1'b1
    } cnt_sel_e;

endpackage
